//--- logic/exe_ops_pkg.sv
`default_nettype none

package exe_ops_pkg;

    // ------------------------------------------------------------
    // alu operations
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        alu_add  = 4'd0,   // signed, traps on overflow
        alu_addu = 4'd1,
        alu_sub  = 4'd2,   // signed, traps on overflow
        alu_subu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_sll  = 4'd10,  // shamt from src_b[4:0]
        alu_srl  = 4'd11,
        alu_sra  = 4'd12,
        alu_lui  = 4'd13   // src_b[15:0] to upper half
    } alu_op_e;

    // ------------------------------------------------------------
    // memory access kinds
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_sb   = 4'd4,
        mem_sh   = 4'd5,
        mem_sw   = 4'd6,
        mem_swl  = 4'd7,   // unaligned store, left part
        mem_swr  = 4'd8    // unaligned store, right part
    } mem_kind_e;

    // cp0 style exception codes
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,   // load address error
        exc_ades = 5'd5,   // store address error
        exc_ov   = 5'd12   // arithmetic overflow
    } exc_code_e;

    // true for every kind that writes memory
    function automatic logic is_store(mem_kind_e kind);
        return kind inside {mem_sb, mem_sh, mem_sw, mem_swl, mem_swr};
    endfunction

endpackage

`default_nettype wire

//--- logic/exe_mem_pkg.sv
`default_nettype none

package exe_mem_pkg;

    // ------------------------------------------------------------
    // memory data word
    // ------------------------------------------------------------
    // same 32 bits, read whole at the stage input and per byte
    // in the lanes and on the write port
    typedef union packed {
        logic [31:0]      word;   // whole word view
        logic [3:0][7:0]  bytes;  // bytes[0] is least significant
    } data_word_u;

    // byte write enables, bit i -> bytes[i]
    typedef logic [3:0] byte_en_t;

endpackage

`default_nettype wire

//--- logic/exe_alu.sv
`default_nettype none

module exe_alu import exe_ops_pkg::*; (
    input  wire alu_op_e      alu_op,
    input  wire [31:0]        src_a,
    input  wire [31:0]        src_b,
    output logic [31:0]       result,
    output logic              overflow
);

    logic [31:0] sum;      // a + b, shared by add/addu
    logic [31:0] diff;     // a - b, shared by sub/subu/compares
    logic [4:0]  shamt;
    logic        add_ov;
    logic        sub_ov;

    assign sum   = src_a + src_b;
    assign diff  = src_a - src_b;
    assign shamt = src_b[4:0];

    // ------------------------------------------------------------
    // overflow by sign comparison
    // ------------------------------------------------------------
    // add: same operand signs, result sign differs
    assign add_ov = (src_a[31] == src_b[31]) && (sum[31] != src_a[31]);
    // sub: operand signs differ, result sign follows b
    assign sub_ov = (src_a[31] != src_b[31]) && (diff[31] != src_a[31]);

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (alu_op)
            alu_add: begin
                result   = sum;
                overflow = add_ov;           // only trapping ops flag
            end
            alu_addu: result = sum;
            alu_sub: begin
                result   = diff;
                overflow = sub_ov;
            end
            alu_subu: result = diff;
            alu_and:  result = src_a & src_b;
            alu_or:   result = src_a | src_b;
            alu_xor:  result = src_a ^ src_b;
            alu_nor:  result = ~(src_a | src_b);
            alu_slt:  result = {31'd0, $signed(src_a) < $signed(src_b)};
            alu_sltu: result = {31'd0, src_a < src_b};
            alu_sll:  result = src_a << shamt;
            alu_srl:  result = src_a >> shamt;
            alu_sra:  result = $unsigned($signed(src_a) >>> shamt);  // sign fill
            alu_lui:  result = {src_b[15:0], 16'd0};
            default: begin
                result   = '0;       // unused encodings
                overflow = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    // the commit stage turns any overflow into an ov exception,
    // so a stray flag on addu/subu would trap a legal instruction
    always_comb begin
        if (!(alu_op inside {alu_add, alu_sub})) begin
            assert (!overflow)
                else $error("overflow raised for non-trapping op %0d", alu_op);
        end
    end

endmodule

`default_nettype wire

//--- logic/store_steer.sv
`default_nettype none

module store_steer import exe_ops_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               go,
    input  wire mem_kind_e    mem_kind,
    input  wire [31:0]        result,
    output logic [1:0]        offset,
    output logic              store_req,
    output mem_kind_e         store_kind,
    output exc_code_e         addr_exc_code
);

    logic access_half;   // lh / sh
    logic access_word;   // lw / sw
    logic is_load;
    logic misaligned;

    // ------------------------------------------------------------
    // access width decode
    // ------------------------------------------------------------
    // byte, swl and swr can sit at any offset
    assign access_half = (mem_kind == mem_lh) || (mem_kind == mem_sh);
    assign access_word = (mem_kind == mem_lw) || (mem_kind == mem_sw);
    assign is_load     = mem_kind inside {mem_lb, mem_lh, mem_lw};

    assign offset = result[1:0];   // byte position inside the word

    // halfword needs even offset, word needs zero offset
    assign misaligned = (access_half && offset[0]) ||
                        (access_word && (offset != 2'd0));

    always_comb begin
        addr_exc_code = exc_none;
        if (misaligned) begin
            addr_exc_code = is_load ? exc_adel : exc_ades;
        end
    end

    // ------------------------------------------------------------
    // store request to the lanes
    // ------------------------------------------------------------
    // lanes only see store kinds, loads collapse to none
    assign store_kind = is_store(mem_kind) ? mem_kind : mem_none;

    // a faulting store must not touch memory
    assign store_req = go && is_store(mem_kind) && !misaligned;

    // lanes rely on this, they never recheck alignment
    req_no_addr_exc: assert property (
        @(posedge clk) disable iff (!rst_n)
        store_req |-> (addr_exc_code == exc_none)
    ) else $error("store request issued with address exception");

endmodule

`default_nettype wire

//--- logic/store_lane.sv
`default_nettype none

module store_lane
    import exe_ops_pkg::*;
    import exe_mem_pkg::*;
#(
    parameter int LANE = 0   // byte lane index, 0..3
) (
    input  wire               store_req,
    input  wire mem_kind_e    store_kind,
    input  wire [1:0]         offset,
    input  wire data_word_u   store_data,
    output logic [7:0]        lane_byte,
    output logic              lane_en
);

    localparam logic [1:0] LANE_IDX = LANE[1:0];

    logic [1:0] src_sel;   // which byte of store_data feeds this lane
    logic       hit;       // lane covered by the current store

    // ------------------------------------------------------------
    // lane rules
    // ------------------------------------------------------------
    // alignment already checked upstream, only the position matters
    always_comb begin
        src_sel = 2'd0;
        hit     = 1'b0;
        case (store_kind)
            mem_sb: begin
                hit     = (offset == LANE_IDX);       // single lane
                src_sel = 2'd0;
            end
            mem_sh: begin
                hit     = (offset[1] == LANE_IDX[1]); // lanes o, o+1
                src_sel = {1'b0, LANE_IDX[0]};
            end
            mem_sw: begin
                hit     = 1'b1;
                src_sel = LANE_IDX;
            end
            mem_swl: begin
                // upper bytes of the register go to the low lanes
                hit     = (LANE_IDX <= offset);
                src_sel = LANE_IDX + 2'd3 - offset;   // i+3-o, no wrap when hit
            end
            mem_swr: begin
                hit     = (LANE_IDX >= offset);
                src_sel = LANE_IDX - offset;          // i-o
            end
            default: begin
                hit     = 1'b0;
                src_sel = 2'd0;
            end
        endcase
    end

    assign lane_byte = store_data.bytes[src_sel];
    assign lane_en   = store_req && hit;   // dead outside a valid store

endmodule

`default_nettype wire

//--- logic/stage_commit.sv
`default_nettype none

module stage_commit
    import exe_ops_pkg::*;
    import exe_mem_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               go,
    input  wire [31:0]        result,
    input  wire               overflow,
    input  wire exc_code_e    addr_exc_code,
    input  wire [4:0]         regnum,
    input  wire [31:0]        lane_bytes,
    input  wire byte_en_t     lane_ens,
    output logic [31:0]       dm_addr,
    output data_word_u        dm_wdata,
    output byte_en_t          dm_we,
    output logic [31:0]       res_out,
    output logic [4:0]        regnum_out,
    output exc_code_e         exc_out,
    output logic              valid_out
);

    exc_code_e exc_next;

    // ------------------------------------------------------------
    // memory write port, same cycle as go
    // ------------------------------------------------------------
    assign dm_addr = {result[31:2], 2'b00};   // word address
    assign dm_we   = lane_ens;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // disabled lanes drive zero
            dm_wdata.bytes[i] = lane_ens[i] ? lane_bytes[8*i +: 8] : 8'd0;
        end
    end

    // overflow wins over address errors
    assign exc_next = overflow ? exc_ov : addr_exc_code;

    // ------------------------------------------------------------
    // stage register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out  <= 1'b0;
            res_out    <= '0;
            regnum_out <= '0;
            exc_out    <= exc_none;
        end else begin
            valid_out <= go;                          // one pulse per go
            exc_out   <= go ? exc_next : exc_none;    // idle slots carry no exception
            if (go) begin
                res_out    <= result;
                regnum_out <= regnum;
            end
        end
    end

    idle_no_exc: assert property (
        @(posedge clk) disable iff (!rst_n)
        !valid_out |-> (exc_out == exc_none)
    ) else $error("exception code present without valid_out");

    // write enables come from the lanes, gated by go in steering
    idle_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !go |-> (dm_we == '0)
    ) else $error("memory write enabled without go");

endmodule

`default_nettype wire

//--- logic/exe_stage.sv
`default_nettype none

module exe_stage
    import exe_ops_pkg::*;
    import exe_mem_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               go,           // one-cycle strobe, no back-pressure
    input  wire alu_op_e      alu_op,
    input  wire [31:0]        src_a,
    input  wire [31:0]        src_b,
    input  wire data_word_u   store_data,
    input  wire mem_kind_e    mem_kind,
    input  wire [4:0]         regnum,
    output logic [31:0]       dm_addr,      // combinational
    output data_word_u        dm_wdata,     // combinational
    output byte_en_t          dm_we,        // combinational
    output logic [31:0]       res_out,      // registered
    output logic [4:0]        regnum_out,   // registered
    output exc_code_e         exc_out,      // registered
    output logic              valid_out     // registered
);

    // ------------------------------------------------------------
    // internal wires
    // ------------------------------------------------------------
    logic [31:0] alu_result;
    logic        alu_overflow;

    logic [1:0]  offset;          // shared by all lanes
    logic        store_req;
    mem_kind_e   store_kind;
    exc_code_e   addr_exc_code;

    logic [31:0] lane_bytes;      // lane i in bits 8i+7:8i
    byte_en_t    lane_ens;

    // ------------------------------------------------------------
    // alu
    // ------------------------------------------------------------
    exe_alu alu_inst (
        .alu_op   (alu_op),
        .src_a    (src_a),
        .src_b    (src_b),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    // address check and lane request
    store_steer steer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .go            (go),
        .mem_kind      (mem_kind),
        .result        (alu_result),
        .offset        (offset),
        .store_req     (store_req),
        .store_kind    (store_kind),
        .addr_exc_code (addr_exc_code)
    );

    // ------------------------------------------------------------
    // byte lanes
    // ------------------------------------------------------------
    for (genvar i = 0; i < 4; i++) begin : g_lane
        store_lane #(
            .LANE (i)
        ) lane_inst (
            .store_req  (store_req),
            .store_kind (store_kind),
            .offset     (offset),
            .store_data (store_data),
            .lane_byte  (lane_bytes[8*i +: 8]),
            .lane_en    (lane_ens[i])
        );
    end

    // write port and stage register
    stage_commit commit_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .go            (go),
        .result        (alu_result),
        .overflow      (alu_overflow),
        .addr_exc_code (addr_exc_code),
        .regnum        (regnum),
        .lane_bytes    (lane_bytes),
        .lane_ens      (lane_ens),
        .dm_addr       (dm_addr),
        .dm_wdata      (dm_wdata),
        .dm_we         (dm_we),
        .res_out       (res_out),
        .regnum_out    (regnum_out),
        .exc_out       (exc_out),
        .valid_out     (valid_out)
    );

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // held low over two rising edges, released mid-cycle
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/exe_stage_tb.sv
`default_nettype none

module exe_stage_tb
    import exe_ops_pkg::*;
    import exe_mem_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_VECTORS = 300;                     // upper bound on issued ops
    localparam int WATCHDOG_NS = NUM_VECTORS * 40 + 2000; // two cycles per op plus slack

    logic        clk;
    logic        rst_n;
    logic        go;
    alu_op_e     alu_op;
    logic [31:0] src_a;
    logic [31:0] src_b;
    data_word_u  store_data;
    mem_kind_e   mem_kind;
    logic [4:0]  regnum;
    logic [31:0] dm_addr;
    data_word_u  dm_wdata;
    byte_en_t    dm_we;
    logic [31:0] res_out;
    logic [4:0]  regnum_out;
    exc_code_e   exc_out;
    logic        valid_out;

    integer     seed = 32'h4e9e_51e2;
    logic [4:0] sent_q[$];   // regnums in issue order

    clock_gen clock_gen_inst (.clk(clk), .rst_n(rst_n));

    exe_stage exe_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .go         (go),
        .alu_op     (alu_op),
        .src_a      (src_a),
        .src_b      (src_b),
        .store_data (store_data),
        .mem_kind   (mem_kind),
        .regnum     (regnum),
        .dm_addr    (dm_addr),
        .dm_wdata   (dm_wdata),
        .dm_we      (dm_we),
        .res_out    (res_out),
        .regnum_out (regnum_out),
        .exc_out    (exc_out),
        .valid_out  (valid_out)
    );

    // ------------------------------------------------------------
    // expected behavior of the stage
    // ------------------------------------------------------------
    function automatic void ref_exe(
        input  alu_op_e     op,
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  mem_kind_e   kind,
        input  data_word_u  data,
        output logic [31:0] res,
        output exc_code_e   exc,
        output byte_en_t    we,
        output data_word_u  wdata
    );
        logic [32:0] wide;   // sign-extended sum for overflow
        logic        ov;
        logic        bad;
        int          o;
        int          src;
        ov = 1'b0;
        wide = '0;
        case (op)
            alu_add, alu_addu: begin
                wide = {a[31], a} + {b[31], b};
                res  = wide[31:0];
                ov   = (op == alu_add) && (wide[32] != wide[31]);
            end
            alu_sub, alu_subu: begin
                wide = {a[31], a} - {b[31], b};
                res  = wide[31:0];
                ov   = (op == alu_sub) && (wide[32] != wide[31]);
            end
            alu_and:  res = a & b;
            alu_or:   res = a | b;
            alu_xor:  res = a ^ b;
            alu_nor:  res = ~(a | b);
            alu_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: res = (a < b) ? 32'd1 : 32'd0;
            alu_sll:  res = a << b[4:0];
            alu_srl:  res = a >> b[4:0];
            alu_sra:  res = 32'($signed(a) >>> b[4:0]);
            alu_lui:  res = {b[15:0], 16'h0000};
            default:  res = 32'd0;
        endcase
        o   = int'(res[1:0]);
        bad = ((kind == mem_lh || kind == mem_sh) && (o % 2 == 1)) ||
              ((kind == mem_lw || kind == mem_sw) && (o != 0));
        if (ov) begin
            exc = exc_ov;                                 // beats address errors
        end else if (bad) begin
            exc = (kind == mem_lh || kind == mem_lw) ? exc_adel : exc_ades;
        end else begin
            exc = exc_none;
        end
        we    = '0;
        wdata = '0;
        if (is_store(kind) && !bad) begin
            for (int i = 0; i < 4; i++) begin
                src = -1;                                 // lane untouched
                case (kind)
                    mem_sb:  if (i == o) src = 0;
                    mem_sh:  if (i == o || i == o + 1) src = i - o;
                    mem_sw:  src = i;
                    mem_swl: if (i <= o) src = i + 3 - o;
                    mem_swr: if (i >= o) src = i - o;
                    default: src = -1;
                endcase
                if (src >= 0) begin
                    we[i]          = 1'b1;
                    wdata.bytes[i] = data.bytes[src];
                end
            end
        end
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("%s is %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_exc(input exc_code_e got, input exc_code_e exp);
        if (got !== exp) begin
            abort_run($sformatf("exc_out is %0d, expected %0d", got, exp));
        end
    endtask

    task automatic check_store(input byte_en_t got_we, input byte_en_t exp_we,
                               input data_word_u got_data, input data_word_u exp_data);
        if (got_we !== exp_we) begin
            abort_run($sformatf("dm_we is %04b, expected %04b", got_we, exp_we));
        end
        if (got_data.word !== exp_data.word) begin
            abort_run($sformatf("dm_wdata is %08h, expected %08h",
                                got_data.word, exp_data.word));
        end
    endtask

    // ------------------------------------------------------------
    // stimulus helpers driven on the falling edge
    // ------------------------------------------------------------
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic issue(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                         input mem_kind_e kind, input logic [31:0] data);
        @(negedge clk);
        go              = 1'b1;
        alu_op          = op;
        src_a           = a;
        src_b           = b;
        mem_kind        = kind;
        store_data.word = data;
        regnum          = 5'(rand_below(32));
        sent_q.push_back(regnum);
    endtask

    // go low with other inputs scrambled so nothing leaks to memory
    task automatic idle();
        @(negedge clk);
        go              = 1'b0;
        alu_op          = alu_op_e'(4'(rand_below(14)));
        src_a           = $random(seed);
        src_b           = $random(seed);
        mem_kind        = mem_kind_e'(4'(rand_below(9)));
        store_data.word = $random(seed);
        regnum          = 5'(rand_below(32));
    endtask

    // ------------------------------------------------------------
    // compare process
    // ------------------------------------------------------------
    // write port checked on the rising edge, stage register on the falling edge
    initial begin : compare
        logic [31:0] exp_res;
        exc_code_e   exp_exc;
        byte_en_t    exp_we;
        data_word_u  exp_wdata;
        logic        pend_valid;
        logic [31:0] pend_res;
        exc_code_e   pend_exc;
        logic [4:0]  exp_regnum;
        pend_valid = 1'b0;
        pend_res   = '0;
        pend_exc   = exc_none;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            pend_valid = go;
            if (go) begin
                ref_exe(alu_op, src_a, src_b, mem_kind, store_data,
                        exp_res, exp_exc, exp_we, exp_wdata);
                check_word("dm_addr", dm_addr, {exp_res[31:2], 2'b00});
                check_store(dm_we, exp_we, dm_wdata, exp_wdata);
                pend_res = exp_res;
                pend_exc = exp_exc;
            end else begin
                check_store(dm_we, '0, dm_wdata, '0);   // no write without go
            end
            @(negedge clk);
            check_word("valid_out", {31'd0, valid_out}, {31'd0, pend_valid});
            if (pend_valid) begin
                exp_regnum = sent_q.pop_front();
                check_word("res_out", res_out, pend_res);
                check_exc(exc_out, pend_exc);
                check_word("regnum_out", {27'd0, regnum_out}, {27'd0, exp_regnum});
            end else begin
                check_exc(exc_out, exc_none);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test sequence did not finish",
                 WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin : drive
        logic [31:0] base;
        logic [31:0] ov_a[4];
        logic [31:0] ov_b[4];
        go              = 1'b0;
        alu_op          = alu_add;
        src_a           = '0;
        src_b           = '0;
        store_data.word = '0;
        mem_kind        = mem_none;
        regnum          = '0;
        wait (rst_n === 1'b1);
        repeat (2) idle();   // quiet cycles straight after reset

        // random ops and random kinds
        for (int n = 0; n < 180; n++) begin
            issue(alu_op_e'(4'(rand_below(14))), $random(seed), $random(seed),
                  mem_kind_e'(4'(rand_below(9))), $random(seed));
            idle();
        end

        // overflow corners with pair k used for add and for sub
        ov_a = '{32'h7fff_ffff, 32'h8000_0000, 32'h7fff_0000, 32'h8000_0001};
        ov_b = '{32'h0000_0001, 32'hffff_ffff, 32'h7fff_0000, 32'h8000_0001};
        for (int k = 0; k < 4; k++) begin
            issue(alu_add, ov_a[k], ov_b[k], mem_none, '0);
            idle();
            issue(alu_addu, ov_a[k], ov_b[k], mem_none, '0);
            idle();
            issue(alu_sub, ov_a[k], ~ov_b[k] + 32'd1, mem_none, '0);   // a - (-b)
            idle();
            issue(alu_subu, ov_a[k], ~ov_b[k] + 32'd1, mem_none, '0);
            idle();
        end

        // sb / sh / sw at aligned offsets
        for (int rep = 0; rep < 4; rep++) begin
            base = $random(seed) & 32'hffff_fffc;
            for (int o = 0; o < 4; o++) begin
                issue(alu_addu, base, 32'(o), mem_sb, $random(seed));
                idle();
            end
            for (int o = 0; o < 4; o += 2) begin
                issue(alu_addu, base, 32'(o), mem_sh, $random(seed));
                idle();
            end
            issue(alu_addu, base, 32'd0, mem_sw, $random(seed));
            idle();
        end

        // partial word stores at every offset
        for (int rep = 0; rep < 2; rep++) begin
            base = $random(seed) & 32'hffff_fffc;
            for (int o = 0; o < 4; o++) begin
                issue(alu_addu, base, 32'(o), mem_swl, $random(seed));
                idle();
                issue(alu_addu, base, 32'(o), mem_swr, $random(seed));
                idle();
            end
        end

        // misaligned halfwords and words
        base = $random(seed) & 32'hffff_fffc;
        for (int o = 1; o < 4; o++) begin
            issue(alu_addu, base, 32'(o), mem_lw, $random(seed));
            idle();
            issue(alu_addu, base, 32'(o), mem_sw, $random(seed));
            idle();
            if (o % 2 == 1) begin
                issue(alu_addu, base, 32'(o), mem_lh, $random(seed));
                idle();
                issue(alu_addu, base, 32'(o), mem_sh, $random(seed));
                idle();
            end
        end

        // go every cycle
        for (int n = 0; n < 16; n++) begin
            issue(alu_op_e'(4'(rand_below(14))), $random(seed), $random(seed),
                  mem_kind_e'(4'(rand_below(9))), $random(seed));
        end
        repeat (3) idle();   // drain

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/exe_ops_pkg.sv
logic/exe_mem_pkg.sv
logic/exe_alu.sv
logic/store_steer.sv
logic/store_lane.sv
logic/stage_commit.sv
logic/exe_stage.sv
tests/clock_gen.sv
tests/exe_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module exe_stage_tb -f list.f -o exe_stage_sim &&
./obj_dir/exe_stage_sim | tee /dev/stderr | grep -qF "TEST RESULT: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
